/* logic/exe_defines.svh */
`ifndef EXE_DEFINES_SVH
`define EXE_DEFINES_SVH

`default_nettype none

//////////////////////////////
// Datapath sizing.
//////////////////////////////

// Integer register width.
`define EXE_XLEN 64

// Extra tag bits from rename.
`define EXE_RB 1

// Physical tag width.
`define EXE_TAG_W (5 + `EXE_RB)

// One entry per physical tag.
`define EXE_PRF_DEPTH (1 << `EXE_TAG_W)

`default_nettype wire

`endif

/* logic/exe_pkg.sv */
`include "exe_defines.svh"

`default_nettype none

package exe_pkg;

	//////////////////////////////
	// Opcodes.
	//////////////////////////////

	// ALU class first, shift class last.
	typedef enum logic [3:0] {
		OP_ADD  = 4'd0,
		OP_SUB  = 4'd1,
		OP_AND  = 4'd2,
		OP_OR   = 4'd3,
		OP_XOR  = 4'd4,
		OP_SLT  = 4'd5,
		OP_SLTU = 4'd6,
		OP_LI   = 4'd7,
		OP_SLL  = 4'd8,
		OP_SRL  = 4'd9,
		OP_SRA  = 4'd10
	} exe_op_e;

	// Physical register tag.
	typedef logic [`EXE_TAG_W-1:0] tag_t;

	//////////////////////////////
	// Stage records.
	//////////////////////////////

	// One issued instruction.
	typedef struct packed {
		exe_op_e     op;
		tag_t        rd;
		tag_t        rs1;
		tag_t        rs2;
		logic [31:0] imm;
		logic        use_imm;
		logic        is32w;
	} issue_t;

	// Shift unit input.
	typedef struct packed {
		logic                 sll;
		logic                 srl;
		logic                 sra;
		tag_t                 rd;
		logic [`EXE_XLEN-1:0] op1;
		logic [`EXE_XLEN-1:0] op2;
		logic                 is32w;
	} shift_param_t;

	// ALU input.
	typedef struct packed {
		exe_op_e              op;
		tag_t                 rd;
		logic [`EXE_XLEN-1:0] op1;
		logic [`EXE_XLEN-1:0] op2;
		logic                 is32w;
	} alu_param_t;

	// Result going back to the register file.
	typedef struct packed {
		logic                 valid;
		tag_t                 rd;
		logic [`EXE_XLEN-1:0] res;
	} wb_t;

endpackage

`default_nettype wire

/* logic/phy_regfile.sv */
`include "exe_defines.svh"

`default_nettype none

module phy_regfile (
	input  wire logic                 CLK,
	input  wire logic                 rst_n,

	// Read ports from decode.
	input  wire exe_pkg::tag_t        rs1_addr,
	input  wire exe_pkg::tag_t        rs2_addr,
	output logic [`EXE_XLEN-1:0]      rs1_data,
	output logic [`EXE_XLEN-1:0]      rs2_data,

	// Write ports from the units.
	input  wire exe_pkg::wb_t         shift_wb,
	input  wire exe_pkg::wb_t         alu_wb
);

	//////////////////////////////
	// Storage.
	//////////////////////////////

	// Whole file clears on reset.
	logic [`EXE_XLEN-1:0] regs [`EXE_PRF_DEPTH];

	// Reads are combinational.
	// A write lands at the edge, so the next cycle sees it.
	assign rs1_data = regs[rs1_addr];
	assign rs2_data = regs[rs2_addr];

	//////////////////////////////
	// Writeback.
	//////////////////////////////

	// One issue per cycle keeps the two tags apart.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXE_PRF_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else begin
			// Shift result.
			if (shift_wb.valid) begin
				regs[shift_wb.rd] <= shift_wb.res;
			end
			// ALU result.
			if (alu_wb.valid) begin
				regs[alu_wb.rd] <= alu_wb.res;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/issue_decode.sv */
`include "exe_defines.svh"

`default_nettype none

module issue_decode (
	input  wire logic                  CLK,
	input  wire logic                  rst_n,
	input  wire logic                  flush,

	// Incoming issue.
	input  wire logic                  issue_valid,
	input  wire exe_pkg::issue_t       issue,

	// Register file read.
	output exe_pkg::tag_t              rs1_addr,
	output exe_pkg::tag_t              rs2_addr,
	input  wire logic [`EXE_XLEN-1:0]  rs1_data,
	input  wire logic [`EXE_XLEN-1:0]  rs2_data,

	// Unit records.
	output logic                       shift_valid,
	output exe_pkg::shift_param_t      shift_param,
	output logic                       alu_valid,
	output exe_pkg::alu_param_t        alu_param
);

	import exe_pkg::*;

	logic                 is_shift;
	logic [`EXE_XLEN-1:0] imm_ext;
	logic [`EXE_XLEN-1:0] op2_sel;
	shift_param_t         shift_next;
	alu_param_t           alu_next;

	//////////////////////////////
	// Operand read.
	//////////////////////////////

	// Source tags straight to the file.
	assign rs1_addr = issue.rs1;
	assign rs2_addr = issue.rs2;

	// Immediate is sign-extended to full width.
	assign imm_ext = {{(`EXE_XLEN-32){issue.imm[31]}}, issue.imm};

	// Second operand.
	assign op2_sel = issue.use_imm ? imm_ext : rs2_data;

	// Opcode class.
	assign is_shift = (issue.op == OP_SLL) || (issue.op == OP_SRL) || (issue.op == OP_SRA);

	//////////////////////////////
	// Record build.
	//////////////////////////////

	always_comb begin
		// Shift flags are one-hot.
		shift_next.sll   = (issue.op == OP_SLL);
		shift_next.srl   = (issue.op == OP_SRL);
		shift_next.sra   = (issue.op == OP_SRA);
		shift_next.rd    = issue.rd;
		shift_next.op1   = rs1_data;
		shift_next.op2   = op2_sel;
		shift_next.is32w = issue.is32w;

		// ALU keeps the opcode itself.
		alu_next.op      = issue.op;
		alu_next.rd      = issue.rd;
		alu_next.op1     = rs1_data;
		alu_next.op2     = op2_sel;
		alu_next.is32w   = issue.is32w;
	end

	//////////////////////////////
	// Decode register.
	//////////////////////////////

	// Only the matching unit's record loads.
	// Flush kills the item at this edge.
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			shift_valid <= 1'b0;
			alu_valid   <= 1'b0;
			shift_param <= '0;
			alu_param   <= '0;
		end else begin
			shift_valid <= issue_valid & is_shift & ~flush;
			alu_valid   <= issue_valid & ~is_shift & ~flush;
			if (issue_valid && is_shift) begin
				shift_param <= shift_next;
			end
			if (issue_valid && !is_shift) begin
				alu_param <= alu_next;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/shift_unit.sv */
`include "exe_defines.svh"

`default_nettype none

module shift_unit (
	input  wire logic                  CLK,
	input  wire logic                  rst_n,
	input  wire logic                  flush,

	input  wire logic                  shift_valid,
	input  wire exe_pkg::shift_param_t shift_param,

	output exe_pkg::wb_t               shift_wb
);

	logic [5:0]           shamt;
	logic [`EXE_XLEN-1:0] left64;
	logic [`EXE_XLEN-1:0] left32;
	logic [`EXE_XLEN-1:0] left_res;
	logic signed [`EXE_XLEN:0] right_op1;
	logic signed [`EXE_XLEN:0] right_full;
	logic [`EXE_XLEN-1:0] res_next;

	//////////////////////////////
	// Shift datapath.
	//////////////////////////////

	// Word form uses five amount bits.
	assign shamt = shift_param.is32w ? {1'b0, shift_param.op2[4:0]} : shift_param.op2[5:0];

	// Left shift, word result sign-extended from bit 31.
	assign left64   = shift_param.op1 << shamt;
	assign left32   = {{(`EXE_XLEN-32){left64[31]}}, left64[31:0]};
	assign left_res = shift_param.is32w ? left32 : left64;

	// Extra top bit carries the fill.
	// Only SRA fills with the sign.
	assign right_op1 = shift_param.is32w ?
		{{(`EXE_XLEN-31){shift_param.op1[31] & shift_param.sra}}, shift_param.op1[31:0]} :
		{shift_param.op1[`EXE_XLEN-1] & shift_param.sra, shift_param.op1};

	// Arithmetic shift covers both SRL and SRA.
	assign right_full = right_op1 >>> shamt;

	// Pick by flag.
	assign res_next = ({`EXE_XLEN{shift_param.sll}} & left_res)
		| ({`EXE_XLEN{shift_param.srl | shift_param.sra}} & right_full[`EXE_XLEN-1:0]);

	//////////////////////////////
	// Result register.
	//////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			shift_wb <= '0;
		end else begin
			shift_wb.valid <= shift_valid & ~flush;
			shift_wb.rd    <= shift_param.rd;
			shift_wb.res   <= res_next;
		end
	end

endmodule

`default_nettype wire

/* logic/alu_unit.sv */
`include "exe_defines.svh"

`default_nettype none

module alu_unit (
	input  wire logic                 CLK,
	input  wire logic                 rst_n,
	input  wire logic                 flush,

	input  wire logic                 alu_valid,
	input  wire exe_pkg::alu_param_t  alu_param,

	output exe_pkg::wb_t              alu_wb
);

	import exe_pkg::*;

	logic [`EXE_XLEN-1:0] op1;
	logic [`EXE_XLEN-1:0] op2;
	logic [`EXE_XLEN-1:0] sum;
	logic [`EXE_XLEN-1:0] diff;
	logic [`EXE_XLEN-1:0] sum_w;
	logic [`EXE_XLEN-1:0] diff_w;
	logic                 lt_s;
	logic                 lt_u;
	logic [`EXE_XLEN-1:0] res_next;

	//////////////////////////////
	// Arithmetic.
	//////////////////////////////

	assign op1 = alu_param.op1;
	assign op2 = alu_param.op2;

	// Full-width add and subtract.
	assign sum  = op1 + op2;
	assign diff = op1 - op2;

	// Word forms sign-extend from bit 31.
	assign sum_w  = {{(`EXE_XLEN-32){sum[31]}}, sum[31:0]};
	assign diff_w = {{(`EXE_XLEN-32){diff[31]}}, diff[31:0]};

	// Compares.
	assign lt_s = $signed(op1) < $signed(op2);
	assign lt_u = op1 < op2;

	//////////////////////////////
	// Result select.
	//////////////////////////////

	always_comb begin
		case (alu_param.op)
			OP_ADD:  res_next = alu_param.is32w ? sum_w : sum;
			OP_SUB:  res_next = alu_param.is32w ? diff_w : diff;
			OP_AND:  res_next = op1 & op2;
			OP_OR:   res_next = op1 | op2;
			OP_XOR:  res_next = op1 ^ op2;
			// Compares give 0 or 1.
			OP_SLT:  res_next = {{(`EXE_XLEN-1){1'b0}}, lt_s};
			OP_SLTU: res_next = {{(`EXE_XLEN-1){1'b0}}, lt_u};
			// Immediate already sits in op2.
			OP_LI:   res_next = op2;
			default: res_next = '0;
		endcase
	end

	//////////////////////////////
	// Result register.
	//////////////////////////////

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			alu_wb <= '0;
		end else begin
			alu_wb.valid <= alu_valid & ~flush;
			alu_wb.rd    <= alu_param.rd;
			alu_wb.res   <= res_next;
		end
	end

endmodule

`default_nettype wire

/* logic/exe_top.sv */
`include "exe_defines.svh"

`default_nettype none

module exe_top (
	input  wire logic             CLK,
	input  wire logic             rst_n,
	input  wire logic             flush,

	input  wire logic             issue_valid,
	input  wire exe_pkg::issue_t  issue,

	output exe_pkg::wb_t          shift_wb,
	output exe_pkg::wb_t          alu_wb
);

	import exe_pkg::*;

	// Register file read path.
	tag_t                 rs1_addr;
	tag_t                 rs2_addr;
	logic [`EXE_XLEN-1:0] rs1_data;
	logic [`EXE_XLEN-1:0] rs2_data;

	// Decode to units.
	logic                 shift_valid;
	shift_param_t         shift_param;
	logic                 alu_valid;
	alu_param_t           alu_param;

	//////////////////////////////
	// Decode and operand read.
	//////////////////////////////

	issue_decode i_decode (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.flush       (flush),
		.issue_valid (issue_valid),
		.issue       (issue),
		.rs1_addr    (rs1_addr),
		.rs2_addr    (rs2_addr),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.shift_valid (shift_valid),
		.shift_param (shift_param),
		.alu_valid   (alu_valid),
		.alu_param   (alu_param)
	);

	// Written back from both units.
	phy_regfile i_regfile (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.rs1_addr (rs1_addr),
		.rs2_addr (rs2_addr),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.shift_wb (shift_wb),
		.alu_wb   (alu_wb)
	);

	//////////////////////////////
	// Execution units.
	//////////////////////////////

	shift_unit i_shift (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.flush       (flush),
		.shift_valid (shift_valid),
		.shift_param (shift_param),
		.shift_wb    (shift_wb)
	);

	alu_unit i_alu (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.flush     (flush),
		.alu_valid (alu_valid),
		.alu_param (alu_param),
		.alu_wb    (alu_wb)
	);

endmodule

`default_nettype wire

/* tests/exe_tb.sv */
`include "exe_defines.svh"

`default_nettype none

module exe_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import exe_pkg::*;

	// One expected writeback.
	typedef struct packed {
		logic [31:0]          due;
		tag_t                 tag;
		logic [`EXE_XLEN-1:0] val;
	} expect_t;

	logic    CLK;
	logic    rst_n;
	logic    flush;
	logic    issue_valid;
	issue_t  issue;
	wb_t     shift_wb;
	wb_t     alu_wb;

	// Mirror of the register file and pending results per port.
	logic [`EXE_XLEN-1:0] model [`EXE_PRF_DEPTH];
	expect_t              shift_q [$];
	expect_t              alu_q [$];
	logic [31:0]          cyc;
	logic [63:0]          rng_state;
	int                   checks;
	int                   errors;
	int                   test_checks;
	int                   test_errors;
	string                test_name;

	exe_top i_dut (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.flush       (flush),
		.issue_valid (issue_valid),
		.issue       (issue),
		.shift_wb    (shift_wb),
		.alu_wb      (alu_wb)
	);

	//////////////////////////////
	// Clock and cycle count.
	//////////////////////////////

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cyc <= cyc + 1;
	end

	//////////////////////////////
	// Reference model.
	//////////////////////////////

	function automatic logic [63:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 7);
		rng_state = rng_state ^ (rng_state << 17);
		return rng_state;
	endfunction

	function automatic logic [63:0] sign_extend_word(input logic [31:0] w);
		return {{32{w[31]}}, w};
	endfunction

	function automatic exe_op_e pick_shift(input logic [1:0] k);
		case (k)
			2'd0:    return OP_SLL;
			2'd1:    return OP_SRL;
			default: return OP_SRA;
		endcase
	endfunction

	function automatic logic [63:0] expected_result(input exe_op_e op, input logic is32w,
		input logic [63:0] a, input logic [63:0] b);
		logic [5:0]  sh;
		logic [31:0] w;
		logic [63:0] r;
		// Word form masks the amount to five bits.
		sh = is32w ? {1'b0, b[4:0]} : b[5:0];
		case (op)
			OP_ADD:  r = is32w ? sign_extend_word(a[31:0] + b[31:0]) : a + b;
			OP_SUB:  r = is32w ? sign_extend_word(a[31:0] - b[31:0]) : a - b;
			OP_AND:  r = a & b;
			OP_OR:   r = a | b;
			OP_XOR:  r = a ^ b;
			OP_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
			OP_SLTU: r = (a < b) ? 64'd1 : 64'd0;
			OP_LI:   r = b;
			OP_SLL: begin
				w = a[31:0] << sh;
				r = is32w ? sign_extend_word(w) : a << sh;
			end
			// Word SRL shifts in zeros.
			OP_SRL:  r = is32w ? {32'd0, a[31:0]} >> sh : a >> sh;
			OP_SRA:  r = is32w ? $signed(sign_extend_word(a[31:0])) >>> sh : $signed(a) >>> sh;
			default: r = 64'd0;
		endcase
		return r;
	endfunction

	//////////////////////////////
	// Writeback checker.
	//////////////////////////////

	task automatic check_port(input string port, input wb_t wb, input logic expect_wb,
		input expect_t e);
		checks++;
		if (expect_wb) begin
			assert (wb.valid) else begin
				errors++;
				$display("test %s: no writeback on the %s port for tag %0d",
					test_name, port, e.tag);
			end
			if (wb.valid) begin
				assert (wb.rd == e.tag) else begin
					errors++;
					$display("mismatch %s %s tag: expected %0d actual %0d",
						test_name, port, e.tag, wb.rd);
				end
				assert (wb.res == e.val) else begin
					errors++;
					$display("mismatch %s %s tag %0d: expected %h actual %h",
						test_name, port, e.tag, e.val, wb.res);
				end
			end
		end else begin
			assert (!wb.valid) else begin
				errors++;
				$display("test %s: unexpected writeback on the %s port for tag %0d",
					test_name, port, wb.rd);
			end
		end
	endtask

	// Outputs are settled at the falling edge.
	always @(negedge CLK) begin
		if (rst_n) begin
			if (shift_q.size() != 0 && shift_q[0].due == cyc) begin
				check_port("shift", shift_wb, 1'b1, shift_q.pop_front());
			end else begin
				check_port("shift", shift_wb, 1'b0, '0);
			end
			if (alu_q.size() != 0 && alu_q[0].due == cyc) begin
				check_port("alu", alu_wb, 1'b1, alu_q.pop_front());
			end else begin
				check_port("alu", alu_wb, 1'b0, '0);
			end
		end
	end

	//////////////////////////////
	// Stimulus tasks.
	//////////////////////////////

	// Killed items are expected to vanish.
	task automatic issue_op(input exe_op_e op, input tag_t rd, input tag_t rs1, input tag_t rs2,
		input logic [31:0] imm, input logic use_imm, input logic is32w, input logic kill);
		logic [63:0] b;
		expect_t     e;
		@(posedge CLK);
		#5;
		issue_valid   = 1'b1;
		issue.op      = op;
		issue.rd      = rd;
		issue.rs1     = rs1;
		issue.rs2     = rs2;
		issue.imm     = imm;
		issue.use_imm = use_imm;
		issue.is32w   = is32w;
		b = use_imm ? sign_extend_word(imm) : model[rs2];
		// Seen on wb two edges after sampling.
		e.due = cyc + 2;
		e.tag = rd;
		e.val = expected_result(op, is32w, model[rs1], b);
		if (!kill) begin
			model[rd] = e.val;
			if (op == OP_SLL || op == OP_SRL || op == OP_SRA) begin
				shift_q.push_back(e);
			end else begin
				alu_q.push_back(e);
			end
		end
	endtask

	// Sources come from tags 0 to 15 and destinations lie above.
	task automatic issue_random(input logic shift_class, input logic is32w,
		input logic [5:0] amt, input logic force_imm);
		logic [63:0] r;
		tag_t        rd;
		r  = next_random();
		rd = tag_t'(16 + (r[13:8] % 48));
		if (shift_class) begin
			issue_op(pick_shift(r[7:6]), rd, tag_t'(r[17:14]), tag_t'(r[21:18]),
				{r[63:38], amt}, r[22] | force_imm, is32w, 1'b0);
		end else begin
			issue_op(exe_op_e'({1'b0, r[2:0]}), rd, tag_t'(r[17:14]), tag_t'(r[21:18]),
				r[63:32], r[4], r[3], 1'b0);
		end
	endtask

	task automatic release_bus();
		@(posedge CLK);
		#5;
		issue_valid = 1'b0;
		flush       = 1'b0;
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((shift_q.size() != 0 || alu_q.size() != 0) && n < 20) begin
			@(posedge CLK);
			n++;
		end
		if (shift_q.size() != 0 || alu_q.size() != 0) begin
			errors++;
			$display("test %s: writebacks still pending after %0d cycles", test_name, n);
			shift_q.delete();
			alu_q.delete();
		end
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_checks = checks;
		test_errors = errors;
	endtask

	task automatic end_test();
		release_bus();
		wait_drain();
		$display("test %s: %0d checks, %0d errors", test_name,
			checks - test_checks, errors - test_errors);
	endtask

	//////////////////////////////
	// Test sequence.
	//////////////////////////////

	initial begin
		logic [63:0] r;
		logic [5:0]  amt;
		tag_t        li_tags [16];
		int          i;
		rst_n       = 1'b0;
		flush       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		cyc         = '0;
		rng_state   = 64'd55;
		checks      = 0;
		errors      = 0;
		for (i = 0; i < `EXE_PRF_DEPTH; i++) begin
			model[i] = '0;
		end

		// Reset and a quiet window.
		begin_test("reset_li");
		repeat (10) @(posedge CLK);
		#5;
		rst_n = 1'b1;
		repeat (10) @(posedge CLK);
		for (i = 0; i < 16; i++) begin
			r = next_random();
			li_tags[i] = r[5:0];
			issue_op(OP_LI, li_tags[i], '0, '0, r[63:32], 1'b1, r[6], 1'b0);
		end
		release_bus();
		wait_drain();
		// Read each one back.
		for (i = 0; i < 16; i++) begin
			issue_op(OP_ADD, li_tags[i], li_tags[i], '0, 32'd0, 1'b1, 1'b0, 1'b0);
		end
		end_test();

		// Source tags 0 and 1 pinned negative and positive.
		begin_test("shift64");
		for (i = 0; i < 16; i++) begin
			r = next_random();
			issue_op(OP_LI, tag_t'(i), '0, '0,
				(i == 0) ? 32'hffff_fffb : (i == 1) ? 32'd7 : r[31:0], 1'b1, 1'b0, 1'b0);
		end
		release_bus();
		wait_drain();
		for (i = 0; i < 40; i++) begin
			r   = next_random();
			amt = (i == 0) ? 6'd0 : (i == 1) ? 6'd63 : (i == 2) ? 6'd32 : r[5:0];
			issue_random(1'b1, 1'b0, amt, i < 3);
		end
		end_test();

		begin_test("shift32");
		for (i = 0; i < 40; i++) begin
			r   = next_random();
			amt = (i == 0) ? 6'd0 : (i == 1) ? 6'd63 : (i == 2) ? 6'd32 : r[5:0];
			issue_random(1'b1, 1'b1, amt, i < 3);
		end
		end_test();

		// Compares across opposite sign bits first.
		begin_test("alu");
		issue_op(OP_SLT, 6'd20, 6'd0, 6'd1, 32'd0, 1'b0, 1'b0, 1'b0);
		issue_op(OP_SLTU, 6'd21, 6'd0, 6'd1, 32'd0, 1'b0, 1'b0, 1'b0);
		issue_op(OP_SLT, 6'd22, 6'd1, 6'd0, 32'd0, 1'b0, 1'b0, 1'b0);
		issue_op(OP_SLTU, 6'd23, 6'd1, 6'd0, 32'd0, 1'b0, 1'b0, 1'b0);
		// Every opcode in both forms with register and immediate operands.
		for (i = 0; i < 32; i++) begin
			r = next_random();
			issue_op(exe_op_e'({1'b0, i[2:0]}), tag_t'(24 + i), tag_t'(r[3:0]), tag_t'(r[7:4]),
				r[63:32], i[4], i[3], 1'b0);
		end
		end_test();

		begin_test("back_to_back");
		for (i = 0; i < 32; i++) begin
			r = next_random();
			issue_random(i[0] == 1'b0, r[0], r[6:1], 1'b0);
		end
		end_test();

		// Oldest item survives while the two younger ones die.
		begin_test("flush");
		issue_op(OP_SLL, 6'd40, 6'd2, 6'd3, 32'd4, 1'b1, 1'b0, 1'b0);
		issue_op(OP_ADD, 6'd41, 6'd2, 6'd3, 32'd0, 1'b0, 1'b0, 1'b1);
		issue_op(OP_SRA, 6'd42, 6'd4, 6'd5, 32'd1, 1'b1, 1'b1, 1'b1);
		flush = 1'b1;
		release_bus();
		// Same pattern with the units swapped.
		issue_op(OP_ADD, 6'd43, 6'd2, 6'd3, 32'd0, 1'b0, 1'b1, 1'b0);
		issue_op(OP_SRL, 6'd44, 6'd4, 6'd5, 32'd0, 1'b0, 1'b1, 1'b1);
		issue_op(OP_XOR, 6'd45, 6'd2, 6'd3, 32'h8000_0001, 1'b1, 1'b0, 1'b1);
		flush = 1'b1;
		release_bus();
		wait_drain();
		for (i = 40; i < 46; i++) begin
			issue_op(OP_ADD, tag_t'(i), tag_t'(i), '0, 32'd0, 1'b1, 1'b0, 1'b0);
		end
		end_test();

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/exe_pkg.sv
logic/phy_regfile.sv
logic/issue_decode.sv
logic/shift_unit.sv
logic/alu_unit.sv
logic/exe_top.sv
tests/exe_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the execute cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module exe_tb -f list.f -o exe_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/exe_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
	exit 1
fi

exit 0
